//--- lsu_top.f
+incdir+.
lsu_data_pkg.sv
lsu_op_pkg.sv
lsu_req_if.sv
lsu_agu.sv
lsu_req_queue.sv
lsu_sequencer.sv
lsu_load_align.sv
lsu_result_pipe.sv
lsu_top.sv
tb_lsu_top.sv

//--- tb_lsu_top.sv
// --------------------
// Testbench for the load/store unit: clock, reset, memory model,
// stimulus, reference model, result checker and watchdog
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_top;

  localparam int CLK_PERIOD     = 4;
  localparam int ROUNDS_ALIGNED = 12;
  localparam int ROUNDS_MISAL   = 6;
  // 8 ops per aligned round, 5 per misaligned round, at most 7 under back-pressure
  localparam int N_OPS          = ROUNDS_ALIGNED * 8 + ROUNDS_MISAL * 5 + 7;

  logic clk_i;
  logic rst_ni;
  logic lsu_valid_i;
  logic lsu_ready_o;
  lsu_op_pkg::lsu_op_e op_i;
  logic [31:0] operand_a_i, imm_i, operand_b_i;
  logic [2:0]  trans_id_i;
  logic        mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  logic [31:0] mem_addr_o, mem_wdata_o, mem_rdata_i;
  logic [3:0]  mem_be_o;
  logic        load_valid_o, load_ex_valid_o, store_valid_o, store_ex_valid_o;
  logic [2:0]  load_trans_id_o, store_trans_id_o;
  logic [31:0] load_result_o, store_result_o;
  logic [3:0]  load_ex_cause_o, store_ex_cause_o;

  integer      seed = 32'h4cfeecb2;
  logic [2:0]  next_id;
  logic        hold_gnt;
  logic [31:0] mem    [64];
  logic [31:0] shadow [64];
  // Expected record {ex_valid, ex_cause, trans_id, result}
  logic [39:0] ld_exp_q [$];
  logic [39:0] st_exp_q [$];
  // Expected memory request {we, word address}
  logic [32:0] mem_exp_q [$];

  lsu_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Expected outcome of one operation with the shadow memory updated in issue order
  function automatic void predict(input lsu_op_pkg::lsu_op_e op, input logic [31:0] addr,
                                  input logic [31:0] data, output logic ex,
                                  output logic is_st, output logic [3:0] cause,
                                  output logic [31:0] res);
    int          nbytes;
    logic [31:0] word;
    case (op)
      lsu_op_pkg::LB, lsu_op_pkg::LBU, lsu_op_pkg::SB: nbytes = 1;
      lsu_op_pkg::LH, lsu_op_pkg::LHU, lsu_op_pkg::SH: nbytes = 2;
      default: nbytes = 4;
    endcase
    is_st = (op == lsu_op_pkg::SB) || (op == lsu_op_pkg::SH) || (op == lsu_op_pkg::SW);
    ex    = ((nbytes == 4) && (addr[1:0] != 2'b00)) || ((nbytes == 2) && addr[0]);
    cause = is_st ? 4'(`LSU_CAUSE_ST_MISALIGNED) : 4'(`LSU_CAUSE_LD_MISALIGNED);
    word  = shadow[addr[7:2]] >> (8 * addr[1:0]);
    res   = '0;
    if (ex) begin
      res = addr;
    end else if (is_st) begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[addr[7:2]][8 * (addr[1:0] + b) +: 8] = data[8 * b +: 8];
      end
    end else begin
      case (op)
        lsu_op_pkg::LB:  res = {{24{word[7]}}, word[7:0]};
        lsu_op_pkg::LBU: res = {24'h0, word[7:0]};
        lsu_op_pkg::LH:  res = {{16{word[15]}}, word[15:0]};
        lsu_op_pkg::LHU: res = {16'h0, word[15:0]};
        default:         res = word;
      endcase
    end
  endfunction

  // Starts on a falling edge and returns on the falling edge after acceptance
  task automatic issue_op(input lsu_op_pkg::lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] data);
    logic [31:0] base;
    logic        ex;
    logic        is_st;
    logic [3:0]  cause;
    logic [31:0] res;
    base = next_random();
    while (!lsu_ready_o) begin
      @(negedge clk_i);
    end
    lsu_valid_i = 1'b1;
    op_i        = op;
    operand_a_i = base;
    imm_i       = addr - base;
    operand_b_i = data;
    trans_id_i  = next_id;
    predict(op, addr, data, ex, is_st, cause, res);
    if (is_st) begin
      st_exp_q.push_back({ex, cause, next_id, res});
    end else begin
      ld_exp_q.push_back({ex, cause, next_id, res});
    end
    if (!ex) begin
      mem_exp_q.push_back({is_st, addr[31:2], 2'b00});
    end
    next_id = next_id + 1'b1;
    @(negedge clk_i);
    lsu_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (ld_exp_q.size() != 0 || st_exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic match_completion(input bit is_load);
    logic [39:0] rec;
    logic [39:0] got;
    string       path;
    path = is_load ? "load" : "store";
    assert ((is_load ? ld_exp_q.size() : st_exp_q.size()) != 0) else begin
      $display("Error at %0d ns: %s result with no operation outstanding", $time, path);
      abort_run();
    end
    if (is_load) begin
      rec = ld_exp_q.pop_front();
      got = {load_ex_valid_o, load_ex_cause_o, load_trans_id_o, load_result_o};
    end else begin
      rec = st_exp_q.pop_front();
      got = {store_ex_valid_o, store_ex_cause_o, store_trans_id_o, store_result_o};
    end
    check_value({path, "_trans_id_o"}, got[34:32], rec[34:32]);
    check_value({path, "_ex_valid_o"}, got[39], rec[39]);
    check_value({path, "_result_o"}, got[31:0], rec[31:0]);
    if (rec[39]) begin
      check_value({path, "_ex_cause_o"}, got[38:35], rec[38:35]);
    end
  endtask

  // --------------------
  // Memory model
  // --------------------
  initial begin : memory_model
    int          gnt_wait;
    int          rv_wait;
    logic [32:0] rec;
    logic [31:0] rd_word;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    hold_gnt     = 1'b0;
    gnt_wait     = -1;
    rv_wait      = 0;
    rd_word      = '0;
    for (int i = 0; i < 64; i++) begin
      mem[i]    = 32'h5a3c_0000 ^ (i * 32'h0104_1041) ^ i;
      shadow[i] = mem[i];
    end
    forever begin
      @(negedge clk_i);
      mem_gnt_i    = 1'b0;
      mem_rvalid_i = 1'b0;
      if (rv_wait > 0) begin
        rv_wait--;
        if (rv_wait == 0) begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = rd_word;
        end
      end else if (mem_req_o && !hold_gnt) begin
        if (gnt_wait < 0) begin
          gnt_wait = next_random() % 4;
        end
        if (gnt_wait == 0) begin
          mem_gnt_i = 1'b1;
          gnt_wait  = -1;
          assert (mem_exp_q.size() != 0) else begin
            $display("Error at %0d ns: memory request with no aligned operation pending", $time);
            abort_run();
          end
          rec = mem_exp_q.pop_front();
          check_value("mem_addr_o", mem_addr_o, rec[31:0]);
          check_value("mem_we_o", mem_we_o, rec[32]);
          if (mem_we_o) begin
            for (int b = 0; b < 4; b++) begin
              if (mem_be_o[b]) begin
                mem[mem_addr_o[7:2]][8 * b +: 8] = mem_wdata_o[8 * b +: 8];
              end
            end
          end else begin
            rd_word = mem[mem_addr_o[7:2]];
            rv_wait = 1 + next_random() % 3;
          end
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  // Completions are compared at the falling edge where outputs are stable
  always @(negedge clk_i) begin
    if (rst_ni && load_valid_o) begin
      match_completion(1'b1);
    end
    if (rst_ni && store_valid_o) begin
      match_completion(1'b0);
    end
  end

  initial begin : watchdog
    repeat (N_OPS * 20) @(posedge clk_i);
    $display("Error at %0d ns: timeout with results still outstanding", $time);
    abort_run();
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : stimulus
    int          accepted;
    logic [31:0] w_addr;
    rst_ni      = 1'b0;
    lsu_valid_i = 1'b0;
    op_i        = lsu_op_pkg::LB;
    operand_a_i = '0;
    imm_i       = '0;
    operand_b_i = '0;
    trans_id_i  = '0;
    next_id     = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Idle state after reset
    repeat (3) begin
      @(negedge clk_i);
      check_value("lsu_ready_o", lsu_ready_o, 1'b1);
      check_value("mem_req_o", mem_req_o, 1'b0);
      check_value("load_valid_o", load_valid_o, 1'b0);
      check_value("store_valid_o", store_valid_o, 1'b0);
    end

    // Stores then loads of every width to the same word
    for (int r = 0; r < ROUNDS_ALIGNED; r++) begin
      w_addr = {24'h0, 6'(next_random()), 2'b00};
      issue_op(lsu_op_pkg::SW, w_addr, next_random());
      issue_op(lsu_op_pkg::SB, w_addr + next_random() % 4, next_random());
      issue_op(lsu_op_pkg::SH, w_addr + 2 * (next_random() % 2), next_random());
      issue_op(lsu_op_pkg::LB, w_addr + next_random() % 4, '0);
      issue_op(lsu_op_pkg::LBU, w_addr + next_random() % 4, '0);
      issue_op(lsu_op_pkg::LH, w_addr + 2 * (next_random() % 2), '0);
      issue_op(lsu_op_pkg::LHU, w_addr + 2 * (next_random() % 2), '0);
      issue_op(lsu_op_pkg::LW, w_addr, '0);
    end

    // Misaligned words and halfwords
    for (int r = 0; r < ROUNDS_MISAL; r++) begin
      w_addr = {24'h0, 6'(next_random()), 2'b00};
      issue_op(lsu_op_pkg::LW, w_addr + 1 + next_random() % 3, '0);
      issue_op(lsu_op_pkg::SW, w_addr + 1 + next_random() % 3, next_random());
      issue_op(lsu_op_pkg::LH, w_addr + 1 + 2 * (next_random() % 2), '0);
      issue_op(lsu_op_pkg::LHU, w_addr + 1 + 2 * (next_random() % 2), '0);
      issue_op(lsu_op_pkg::SH, w_addr + 1 + 2 * (next_random() % 2), next_random());
    end

    // --------------------
    // Queue fills behind a store whose grant is withheld
    // --------------------
    wait_idle();
    hold_gnt = 1'b1;
    w_addr   = 32'h0000_0014;
    issue_op(lsu_op_pkg::SW, w_addr, next_random());
    accepted = 0;
    while (lsu_ready_o && accepted < `LSU_QUEUE_DEPTH + 1) begin
      issue_op(lsu_op_pkg::LW, w_addr, '0);
      accepted++;
    end
    assert (!lsu_ready_o && accepted <= `LSU_QUEUE_DEPTH) else begin
      $display("Error at %0d ns: lsu_ready_o still high after %0d further issues",
               $time, accepted);
      abort_run();
    end
    repeat (20) @(negedge clk_i);
    hold_gnt = 1'b0;
    issue_op(lsu_op_pkg::LBU, w_addr + 3, '0);
    issue_op(lsu_op_pkg::LH, w_addr + 2, '0);
    issue_op(lsu_op_pkg::LB, w_addr + 1, '0);

    wait_idle();
    repeat (5) @(negedge clk_i);
    if (mem_exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Error at %0d ns: %0d memory requests never reached the port",
               $time, mem_exp_q.size());
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- lsu_top.sv
// --------------------
// Load/store unit top level: AGU, request queue, sequencer,
// load alignment and the two result pipes
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Issue port
  input  logic                    lsu_valid_i,
  input  lsu_op_pkg::lsu_op_e     op_i,
  input  lsu_data_pkg::xlen_t     operand_a_i,
  input  lsu_data_pkg::xlen_t     imm_i,
  input  lsu_data_pkg::xlen_t     operand_b_i,
  input  lsu_data_pkg::trans_id_t trans_id_i,
  output logic                    lsu_ready_o,
  // Memory port
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output lsu_data_pkg::addr_t     mem_addr_o,
  output lsu_data_pkg::be_t       mem_be_o,
  output lsu_data_pkg::xlen_t     mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  input  lsu_data_pkg::xlen_t     mem_rdata_i,
  // Load results
  output logic                    load_valid_o,
  output lsu_data_pkg::trans_id_t load_trans_id_o,
  output lsu_data_pkg::xlen_t     load_result_o,
  output logic                    load_ex_valid_o,
  output lsu_op_pkg::cause_t      load_ex_cause_o,
  // Store results
  output logic                    store_valid_o,
  output lsu_data_pkg::trans_id_t store_trans_id_o,
  output lsu_data_pkg::xlen_t     store_result_o,
  output logic                    store_ex_valid_o,
  output lsu_op_pkg::cause_t      store_ex_cause_o
);

  lsu_op_pkg::fu_e         agu_fu;
  lsu_data_pkg::addr_t     agu_addr;
  lsu_data_pkg::be_t       agu_be;
  lsu_data_pkg::xlen_t     agu_wdata;
  logic                    agu_ex_valid;
  lsu_op_pkg::cause_t      agu_ex_cause;

  logic                    ld_done;
  logic                    st_done;
  lsu_data_pkg::trans_id_t done_trans_id;
  logic                    done_ex_valid;
  lsu_op_pkg::cause_t      done_ex_cause;
  lsu_data_pkg::addr_t     done_addr;
  lsu_op_pkg::lsu_op_e     done_op;
  lsu_data_pkg::xlen_t     ld_aligned;
  lsu_data_pkg::xlen_t     ld_result;
  lsu_data_pkg::xlen_t     st_result;

  lsu_req_if head_if ();

  lsu_agu agu_i (
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .imm_i       (imm_i),
    .operand_b_i (operand_b_i),
    .fu_o        (agu_fu),
    .addr_o      (agu_addr),
    .be_o        (agu_be),
    .wdata_o     (agu_wdata),
    .ex_valid_o  (agu_ex_valid),
    .ex_cause_o  (agu_ex_cause)
  );

  lsu_req_queue queue_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (lsu_valid_i),
    .fu_i        (agu_fu),
    .op_i        (op_i),
    .addr_i      (agu_addr),
    .be_i        (agu_be),
    .wdata_i     (agu_wdata),
    .trans_id_i  (trans_id_i),
    .ex_valid_i  (agu_ex_valid),
    .ex_cause_i  (agu_ex_cause),
    .ready_o     (lsu_ready_o),
    .head        (head_if.queue)
  );

  lsu_sequencer seq_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .head            (head_if.seq),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .mem_addr_o      (mem_addr_o),
    .mem_be_o        (mem_be_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_gnt_i       (mem_gnt_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .ld_done_o       (ld_done),
    .st_done_o       (st_done),
    .done_trans_id_o (done_trans_id),
    .done_ex_valid_o (done_ex_valid),
    .done_ex_cause_o (done_ex_cause),
    .done_addr_o     (done_addr),
    .done_op_o       (done_op)
  );

  lsu_load_align align_i (
    .rdata_i  (mem_rdata_i),
    .addr_i   (done_addr),
    .op_i     (done_op),
    .result_o (ld_aligned)
  );

  // Exceptions report the faulting address as result
  assign ld_result = done_ex_valid ? done_addr : ld_aligned;
  assign st_result = done_ex_valid ? done_addr : '0;

  lsu_result_pipe load_pipe_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (ld_done),
    .trans_id_i (done_trans_id),
    .result_i   (ld_result),
    .ex_valid_i (done_ex_valid),
    .ex_cause_i (done_ex_cause),
    .valid_o    (load_valid_o),
    .trans_id_o (load_trans_id_o),
    .result_o   (load_result_o),
    .ex_valid_o (load_ex_valid_o),
    .ex_cause_o (load_ex_cause_o)
  );

  lsu_result_pipe store_pipe_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .valid_i    (st_done),
    .trans_id_i (done_trans_id),
    .result_i   (st_result),
    .ex_valid_i (done_ex_valid),
    .ex_cause_i (done_ex_cause),
    .valid_o    (store_valid_o),
    .trans_id_o (store_trans_id_o),
    .result_o   (store_result_o),
    .ex_valid_o (store_ex_valid_o),
    .ex_cause_o (store_ex_cause_o)
  );

endmodule

`default_nettype wire

//--- lsu_result_pipe.sv
// --------------------
// Output register chain for one result path
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_result_pipe #(
  parameter int unsigned STAGES = `LSU_RESULT_STAGES
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid_i,
  input  lsu_data_pkg::trans_id_t trans_id_i,
  input  lsu_data_pkg::xlen_t     result_i,
  input  logic                    ex_valid_i,
  input  lsu_op_pkg::cause_t      ex_cause_i,
  output logic                    valid_o,
  output lsu_data_pkg::trans_id_t trans_id_o,
  output lsu_data_pkg::xlen_t     result_o,
  output logic                    ex_valid_o,
  output lsu_op_pkg::cause_t      ex_cause_o
);

  logic [STAGES-1:0]       valid_q;
  lsu_data_pkg::trans_id_t trans_id_q [STAGES];
  lsu_data_pkg::xlen_t     result_q   [STAGES];
  logic                    ex_valid_q [STAGES];
  lsu_op_pkg::cause_t      ex_cause_q [STAGES];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload follows its valid bit
  always_ff @(posedge clk_i) begin
    trans_id_q[0] <= trans_id_i;
    result_q[0]   <= result_i;
    ex_valid_q[0] <= ex_valid_i;
    ex_cause_q[0] <= ex_cause_i;
    for (int i = 1; i < STAGES; i++) begin
      trans_id_q[i] <= trans_id_q[i-1];
      result_q[i]   <= result_q[i-1];
      ex_valid_q[i] <= ex_valid_q[i-1];
      ex_cause_q[i] <= ex_cause_q[i-1];
    end
  end

  assign valid_o    = valid_q[STAGES-1];
  assign trans_id_o = trans_id_q[STAGES-1];
  assign result_o   = result_q[STAGES-1];
  assign ex_valid_o = ex_valid_q[STAGES-1];
  assign ex_cause_o = ex_cause_q[STAGES-1];

endmodule

`default_nettype wire

//--- lsu_load_align.sv
// --------------------
// Load data alignment with sign or zero extension
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  lsu_data_pkg::xlen_t rdata_i,
  input  lsu_data_pkg::addr_t addr_i,
  input  lsu_op_pkg::lsu_op_e op_i,
  output lsu_data_pkg::xlen_t result_o
);

  // Addressed byte moved down to lane 0
  lsu_data_pkg::xlen_t shifted;

  assign shifted = rdata_i >> {addr_i[1:0], 3'b000};

  always_comb begin
    case (op_i)
      lsu_op_pkg::LB:  result_o = lsu_data_pkg::xlen_t'($signed(shifted[7:0]));
      lsu_op_pkg::LBU: result_o = lsu_data_pkg::xlen_t'(shifted[7:0]);
      lsu_op_pkg::LH:  result_o = lsu_data_pkg::xlen_t'($signed(shifted[15:0]));
      lsu_op_pkg::LHU: result_o = lsu_data_pkg::xlen_t'(shifted[15:0]);
      default:         result_o = rdata_i;
    endcase
  end

endmodule

`default_nettype wire

//--- lsu_sequencer.sv
// --------------------
// Memory sequencer: issues the queue head on the req/gnt/rvalid port
// one at a time and signals completions
// --------------------

`timescale 1ns/1ps
`default_nettype none

module lsu_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  lsu_req_if.seq                  head,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output lsu_data_pkg::addr_t     mem_addr_o,
  output lsu_data_pkg::be_t       mem_be_o,
  output lsu_data_pkg::xlen_t     mem_wdata_o,
  input  logic                    mem_gnt_i,
  input  logic                    mem_rvalid_i,
  output logic                    ld_done_o,
  output logic                    st_done_o,
  output lsu_data_pkg::trans_id_t done_trans_id_o,
  output logic                    done_ex_valid_o,
  output lsu_op_pkg::cause_t      done_ex_cause_o,
  output lsu_data_pkg::addr_t     done_addr_o,
  output lsu_op_pkg::lsu_op_e     done_op_o
);

  lsu_op_pkg::seq_state_e state_q;
  lsu_op_pkg::seq_state_e state_d;
  logic                   is_store;
  logic                   done;

  assign is_store = (head.fu == lsu_op_pkg::STORE);

  // --------------------
  // Control FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    done    = 1'b0;
    case (state_q)
      lsu_op_pkg::IDLE: begin
        if (head.valid) begin
          // Misaligned requests never reach memory
          if (head.ex_valid) begin
            done = 1'b1;
          end else begin
            state_d = lsu_op_pkg::REQ;
          end
        end
      end
      lsu_op_pkg::REQ: begin
        if (mem_gnt_i) begin
          if (is_store) begin
            done    = 1'b1;
            state_d = lsu_op_pkg::IDLE;
          end else begin
            state_d = lsu_op_pkg::WAIT;
          end
        end
      end
      lsu_op_pkg::WAIT: begin
        if (mem_rvalid_i) begin
          done    = 1'b1;
          state_d = lsu_op_pkg::IDLE;
        end
      end
      default: state_d = lsu_op_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lsu_op_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // --------------------
  // Memory port
  // --------------------
  // Head stays put until completion, so the request is stable
  assign mem_req_o   = (state_q == lsu_op_pkg::REQ);
  assign mem_we_o    = is_store;
  assign mem_addr_o  = head.addr & ~lsu_data_pkg::addr_t'(3);
  assign mem_be_o    = head.be;
  assign mem_wdata_o = head.wdata;

  // --------------------
  // Completion
  // --------------------
  assign head.pop        = done;
  assign ld_done_o       = done && !is_store;
  assign st_done_o       = done && is_store;
  assign done_trans_id_o = head.trans_id;
  assign done_ex_valid_o = head.ex_valid;
  assign done_ex_cause_o = head.ex_cause;
  assign done_addr_o     = head.addr;
  assign done_op_o       = head.op;

endmodule

`default_nettype wire

//--- lsu_req_queue.sv
// --------------------
// In-order request queue between the AGU and the sequencer,
// source of the issue ready signal
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_req_queue (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  lsu_op_pkg::fu_e         fu_i,
  input  lsu_op_pkg::lsu_op_e     op_i,
  input  lsu_data_pkg::addr_t     addr_i,
  input  lsu_data_pkg::be_t       be_i,
  input  lsu_data_pkg::xlen_t     wdata_i,
  input  lsu_data_pkg::trans_id_t trans_id_i,
  input  logic                    ex_valid_i,
  input  lsu_op_pkg::cause_t      ex_cause_i,
  output logic                    ready_o,
  lsu_req_if.queue                head
);

  localparam int unsigned DEPTH = `LSU_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Entry storage
  lsu_op_pkg::fu_e         fu_mem       [DEPTH];
  lsu_op_pkg::lsu_op_e     op_mem       [DEPTH];
  lsu_data_pkg::addr_t     addr_mem     [DEPTH];
  lsu_data_pkg::be_t       be_mem       [DEPTH];
  lsu_data_pkg::xlen_t     wdata_mem    [DEPTH];
  lsu_data_pkg::trans_id_t trans_id_mem [DEPTH];
  logic                    ex_valid_mem [DEPTH];
  lsu_op_pkg::cause_t      ex_cause_mem [DEPTH];

  assign ready_o = (count_q < CNT_W'(DEPTH));
  assign do_push = push_i && ready_o;
  assign do_pop  = head.pop && head.valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      fu_mem[wr_ptr_q]       <= fu_i;
      op_mem[wr_ptr_q]       <= op_i;
      addr_mem[wr_ptr_q]     <= addr_i;
      be_mem[wr_ptr_q]       <= be_i;
      wdata_mem[wr_ptr_q]    <= wdata_i;
      trans_id_mem[wr_ptr_q] <= trans_id_i;
      ex_valid_mem[wr_ptr_q] <= ex_valid_i;
      ex_cause_mem[wr_ptr_q] <= ex_cause_i;
    end
  end

  // Head of the queue
  assign head.valid    = (count_q != '0);
  assign head.fu       = fu_mem[rd_ptr_q];
  assign head.op       = op_mem[rd_ptr_q];
  assign head.addr     = addr_mem[rd_ptr_q];
  assign head.be       = be_mem[rd_ptr_q];
  assign head.wdata    = wdata_mem[rd_ptr_q];
  assign head.trans_id = trans_id_mem[rd_ptr_q];
  assign head.ex_valid = ex_valid_mem[rd_ptr_q];
  assign head.ex_cause = ex_cause_mem[rd_ptr_q];

endmodule

`default_nettype wire

//--- lsu_agu.sv
// --------------------
// Address generation: base plus immediate, byte enables, store lane
// shift and misalignment detection
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_agu (
  input  lsu_op_pkg::lsu_op_e op_i,
  input  lsu_data_pkg::xlen_t operand_a_i,
  input  lsu_data_pkg::xlen_t imm_i,
  input  lsu_data_pkg::xlen_t operand_b_i,
  output lsu_op_pkg::fu_e     fu_o,
  output lsu_data_pkg::addr_t addr_o,
  output lsu_data_pkg::be_t   be_o,
  output lsu_data_pkg::xlen_t wdata_o,
  output logic                ex_valid_o,
  output lsu_op_pkg::cause_t  ex_cause_o
);

  // Log2 of the transfer size in bytes
  logic [1:0] xfer_size;

  assign addr_o = operand_a_i + imm_i;

  // --------------------
  // Operation decode
  // --------------------
  always_comb begin
    fu_o      = lsu_op_pkg::LOAD;
    xfer_size = 2'd2;
    case (op_i)
      lsu_op_pkg::LB, lsu_op_pkg::LBU: xfer_size = 2'd0;
      lsu_op_pkg::LH, lsu_op_pkg::LHU: xfer_size = 2'd1;
      lsu_op_pkg::SB: begin
        fu_o      = lsu_op_pkg::STORE;
        xfer_size = 2'd0;
      end
      lsu_op_pkg::SH: begin
        fu_o      = lsu_op_pkg::STORE;
        xfer_size = 2'd1;
      end
      lsu_op_pkg::SW: fu_o = lsu_op_pkg::STORE;
      default: ;
    endcase
  end

  // --------------------
  // Byte lanes
  // --------------------
  always_comb begin
    case (xfer_size)
      2'd0:    be_o = lsu_data_pkg::be_t'(1) << addr_o[1:0];
      2'd1:    be_o = lsu_data_pkg::be_t'(3) << addr_o[1:0];
      default: be_o = '1;
    endcase
  end

  // Store data moves up to the addressed lane
  assign wdata_o = operand_b_i << {addr_o[1:0], 3'b000};

  // --------------------
  // Misalignment
  // --------------------
  assign ex_valid_o = ((xfer_size == 2'd2) && (addr_o[1:0] != 2'b00)) ||
                      ((xfer_size == 2'd1) && addr_o[0]);

  assign ex_cause_o = (fu_o == lsu_op_pkg::STORE) ?
                      lsu_op_pkg::cause_t'(`LSU_CAUSE_ST_MISALIGNED) :
                      lsu_op_pkg::cause_t'(`LSU_CAUSE_LD_MISALIGNED);

endmodule

`default_nettype wire

//--- lsu_req_if.sv
// --------------------
// Queued request from the request queue head to the sequencer,
// with the pop handshake going back
// --------------------

`timescale 1ns/1ps
`default_nettype none

interface lsu_req_if;

  // Head entry, meaningful while valid is high
  logic                    valid;
  lsu_op_pkg::fu_e         fu;
  lsu_op_pkg::lsu_op_e     op;
  lsu_data_pkg::addr_t     addr;
  lsu_data_pkg::be_t       be;
  lsu_data_pkg::xlen_t     wdata;
  lsu_data_pkg::trans_id_t trans_id;
  logic                    ex_valid;
  lsu_op_pkg::cause_t      ex_cause;

  // One-cycle pulse removes the head
  logic                    pop;

  modport queue (
    output valid, fu, op, addr, be, wdata, trans_id, ex_valid, ex_cause,
    input  pop
  );

  modport seq (
    input  valid, fu, op, addr, be, wdata, trans_id, ex_valid, ex_cause,
    output pop
  );

endinterface

`default_nettype wire

//--- lsu_op_pkg.sv
// --------------------
// Operation types: load/store opcodes, functional unit select,
// exception cause and sequencer FSM states
// --------------------

`default_nettype none

package lsu_op_pkg;

  // Supported loads and stores
  typedef enum logic [3:0] {
    LB  = 4'h0,
    LBU = 4'h1,
    LH  = 4'h2,
    LHU = 4'h3,
    LW  = 4'h4,
    SB  = 4'h5,
    SH  = 4'h6,
    SW  = 4'h7
  } lsu_op_e;

  // Which result path an operation completes on
  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } fu_e;

  // Exception cause code
  typedef logic [3:0] cause_t;

  // Memory sequencer states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,
    WAIT = 2'd2
  } seq_state_e;

endpackage

`default_nettype wire

//--- lsu_data_pkg.sv
// --------------------
// Data path types: data word, byte address, byte enables and
// transaction ID
// --------------------

`default_nettype none

`include "lsu_defs.svh"

package lsu_data_pkg;

  // One data word
  typedef logic [`LSU_XLEN-1:0] xlen_t;

  // Byte address, no translation
  typedef logic [`LSU_XLEN-1:0] addr_t;

  // One enable per byte lane
  typedef logic [`LSU_XLEN/8-1:0] be_t;

  // Tag returned with each completion
  typedef logic [2:0] trans_id_t;

endpackage

`default_nettype wire

//--- lsu_defs.svh
// --------------------
// Build-time constants of the load/store unit: data width, request queue
// depth, output register stages and misaligned-access exception causes
// --------------------

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// Data and address width
`define LSU_XLEN 32

// Entries in the request queue
`define LSU_QUEUE_DEPTH 2

// Register stages on each result path
`define LSU_RESULT_STAGES 1

// RISC-V exception causes
`define LSU_CAUSE_LD_MISALIGNED 4
`define LSU_CAUSE_ST_MISALIGNED 6

`endif
